// ==== vlog.f ====
design/rvIsaPkg.sv
design/rvBusPkg.sv
design/rvDecoder.sv
design/rvRegFile.sv
design/rvAlu.sv
design/rvLoadStore.sv
design/rvCore.sv
bench/tbClock.sv
bench/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvcore

sources:
  - files:
      - design/rvIsaPkg.sv
      - design/rvBusPkg.sv
      - design/rvDecoder.sv
      - design/rvRegFile.sv
      - design/rvAlu.sv
      - design/rvLoadStore.sv
      - design/rvCore.sv
  - target: test
    files:
      - bench/tbClock.sv
      - bench/rvCoreTb.sv

// ==== bench/rvCoreTb.sv ====
// Testbench for the RV32I core
// Shared memory model with optional random busy, a hand-assembled program
// and a table of expected stores that the program must produce in order.
// The program jumps back to its start and runs twice, first with busy off and then random
`timescale 1ns/1ns

module rvCoreTb;
   import rvIsaPkg::*;

   localparam word_t resetAddr = 32'h0001_0000;
   localparam word_t resultBase = 32'h0000_0200;
   localparam word_t dataAddr = 32'h0000_03F0;
   localparam word_t dataWord = 32'h80F1_7F82;

   logic clk;
   logic reset;
   word_t memAddr;
   word_t memWdata;
   logic [3:0] memWmask;
   logic memRstrb;
   word_t memRdata;
   logic memRbusy;
   logic memWbusy;

   word_t mem [256];
   integer seed;
   logic randomBusy;
   // Bus requests seen at the falling edge and served after the next rising edge
   logic rdReq;
   word_t reqAddr;
   word_t reqWdata;
   logic [3:0] reqMask;

   // Program and table construction state
   int pcWord;
   int slot;
   word_t expAddr [$];
   word_t expData [$];
   logic [3:0] expMask [$];
   string expLabel [$];

   tbClock clkGen (
      .clk   (clk),
      .reset (reset)
   );

   rvCore #(
      .resetAddr (resetAddr),
      .addrWidth (24)
   ) dut0 (
      .clk      (clk),
      .reset    (reset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRstrb (memRstrb),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   // Instruction encoders
   function automatic word_t rType(logic [2:0] f3, logic [6:0] f7, int rd, int rs1, int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
   endfunction

   function automatic word_t iType(logic [6:0] op, logic [2:0] f3, int rd, int rs1, word_t imm);
      return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
   endfunction

   function automatic word_t sType(logic [2:0] f3, int rs1, int rs2, word_t imm);
      return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t bType(logic [2:0] f3, int rs1, int rs2, word_t imm);
      return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t uType(logic [6:0] op, int rd, logic [19:0] imm);
      return {imm, 5'(rd), op};
   endfunction

   function automatic word_t jType(int rd, word_t imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
   endfunction

   task automatic emit(input word_t instr);
      mem[pcWord] = instr;
      pcWord++;
   endtask

   task automatic expectStore(input word_t a, input word_t d, input logic [3:0] m,
                              input string label);
      expAddr.push_back(a);
      expData.push_back(d);
      expMask.push_back(m);
      expLabel.push_back(label);
   endtask

   // SW rs to the next result slot
   task automatic storeWord(input int rs, input word_t d, input string label);
      emit(sType(3'b010, 1, rs, slot));
      expectStore(resultBase + slot, d, 4'hF, label);
      slot += 4;
   endtask

   // Branch over a fall-through marker so each path stores its own marker
   task automatic branchCase(input logic [2:0] f3, input int rs1, input int rs2,
                             input logic expTaken, input int k, input string label);
      emit(bType(f3, rs1, rs2, 12));
      emit(iType(7'b0010011, 3'b000, 9, 0, 200 + k));
      emit(jType(0, 8));
      emit(iType(7'b0010011, 3'b000, 9, 0, 100 + k));
      storeWord(9, expTaken ? 100 + k : 200 + k, label);
   endtask

   task automatic compare(input word_t actual, input word_t expected, input string label);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s: got %h, expected %h", $time, label, actual,
                  expected);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   // Requests are sampled mid-cycle where the core outputs are settled
   always @(negedge clk) begin
      rdReq    <= memRstrb;
      reqAddr  <= memAddr;
      reqWdata <= memWdata;
      reqMask  <= memWmask;
   end

   always @(posedge clk) begin
      #1;
      if (rdReq) begin
         memRdata = mem[reqAddr[9:2]];
      end
      for (int i = 0; i < 4; i++) begin
         if (reqMask[i]) begin
            mem[reqAddr[9:2]][8*i +: 8] = reqWdata[8*i +: 8];
         end
      end
      if (randomBusy) begin
         memRbusy = $random(seed) & 1;
         memWbusy = $random(seed) & 1;
      end else begin
         memRbusy = 1'b0;
         memWbusy = 1'b0;
      end
   end

   initial begin
      word_t a;
      word_t b;
      word_t p;
      int cnt;

      seed = 54;
      randomBusy = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      rdReq = 1'b0;
      reqMask = '0;
      a = -5;
      b = 7;
      pcWord = 0;
      slot = 0;
      // Background fill depends on the whole word address
      for (int i = 0; i < 256; i++) begin
         mem[i] = {16'hDEAD, 8'(i), 8'(~i)};
      end
      mem[dataAddr[9:2]] = dataWord;

      // x1 holds the result base, x2 = -5 and x3 = 7
      emit(iType(7'b0010011, 3'b000, 1, 0, resultBase));
      emit(iType(7'b0010011, 3'b000, 2, 0, a));
      emit(iType(7'b0010011, 3'b000, 3, 0, b));
      storeWord(2, a, "addi");
      emit(rType(3'b000, 7'h00, 5, 2, 3));
      storeWord(5, a + b, "add");
      emit(rType(3'b000, 7'h20, 5, 3, 2));
      storeWord(5, b - a, "sub");
      emit(rType(3'b111, 7'h00, 5, 2, 3));
      storeWord(5, a & b, "and");
      emit(rType(3'b110, 7'h00, 5, 2, 3));
      storeWord(5, a | b, "or");
      emit(rType(3'b100, 7'h00, 5, 2, 3));
      storeWord(5, a ^ b, "xor");
      emit(rType(3'b010, 7'h00, 5, 2, 3));
      storeWord(5, word_t'($signed(a) < $signed(b)), "slt");
      emit(rType(3'b011, 7'h00, 5, 2, 3));
      storeWord(5, word_t'(a < b), "sltu");
      emit(rType(3'b001, 7'h00, 5, 3, 3));
      storeWord(5, b << b[4:0], "sll");
      emit(rType(3'b101, 7'h00, 5, 2, 3));
      storeWord(5, a >> b[4:0], "srl");
      emit(rType(3'b101, 7'h20, 5, 2, 3));
      storeWord(5, $signed(a) >>> b[4:0], "sra");
      emit(uType(7'b0110111, 5, 20'hABCDE));
      storeWord(5, 32'hABCD_E000, "lui");
      p = resetAddr + pcWord * 4;
      emit(uType(7'b0010111, 5, 20'h00001));
      storeWord(5, p + 32'h1000, "auipc");

      // x6 = 0x11223344 is stored by byte and halfword at every offset
      emit(uType(7'b0110111, 6, 20'h11223));
      emit(iType(7'b0010011, 3'b000, 6, 6, 32'h344));
      for (int i = 0; i < 4; i++) begin
         emit(sType(3'b000, 1, 6, slot + i));
         expectStore(resultBase + slot + i, {4{8'h44}}, 4'b0001 << i, "sb");
      end
      emit(sType(3'b001, 1, 6, slot));
      expectStore(resultBase + slot, {2{16'h3344}}, 4'b0011, "sh low");
      emit(sType(3'b001, 1, 6, slot + 2));
      expectStore(resultBase + slot + 2, {2{16'h3344}}, 4'b1100, "sh high");
      slot += 4;

      // Loads of the known word through x7
      emit(iType(7'b0010011, 3'b000, 7, 0, dataAddr));
      emit(iType(7'b0000011, 3'b000, 8, 7, 0));
      storeWord(8, {{24{dataWord[7]}}, dataWord[7:0]}, "lb 0");
      emit(iType(7'b0000011, 3'b000, 8, 7, 1));
      storeWord(8, {{24{dataWord[15]}}, dataWord[15:8]}, "lb 1");
      emit(iType(7'b0000011, 3'b000, 8, 7, 3));
      storeWord(8, {{24{dataWord[31]}}, dataWord[31:24]}, "lb 3");
      emit(iType(7'b0000011, 3'b100, 8, 7, 2));
      storeWord(8, {24'b0, dataWord[23:16]}, "lbu 2");
      emit(iType(7'b0000011, 3'b001, 8, 7, 2));
      storeWord(8, {{16{dataWord[31]}}, dataWord[31:16]}, "lh 2");
      emit(iType(7'b0000011, 3'b101, 8, 7, 0));
      storeWord(8, {16'b0, dataWord[15:0]}, "lhu 0");
      emit(iType(7'b0000011, 3'b010, 8, 7, 0));
      storeWord(8, dataWord, "lw");

      // Branches on x2 = -5 and x3 = 7
      branchCase(3'b000, 3, 3, b == b, 0, "beq taken");
      branchCase(3'b000, 2, 3, a == b, 1, "beq not taken");
      branchCase(3'b001, 2, 3, a != b, 2, "bne taken");
      branchCase(3'b001, 3, 3, b != b, 3, "bne not taken");
      branchCase(3'b100, 2, 3, $signed(a) < $signed(b), 4, "blt");
      branchCase(3'b101, 2, 3, $signed(a) >= $signed(b), 5, "bge");
      branchCase(3'b110, 2, 3, a < b, 6, "bltu");
      branchCase(3'b111, 2, 3, a >= b, 7, "bgeu");

      // JAL skips a bad store and links the next PC
      p = resetAddr + pcWord * 4;
      emit(jType(10, 8));
      emit(sType(3'b010, 1, 0, 0));
      storeWord(10, p + 4, "jal link");
      // JALR with an odd offset lands with target bit 0 cleared
      p = resetAddr + pcWord * 4;
      emit(uType(7'b0010111, 11, 20'h0));
      emit(iType(7'b1100111, 3'b000, 12, 11, 13));
      emit(sType(3'b010, 1, 0, 0));
      storeWord(12, p + 8, "jalr link");
      // Back to the start for the second pass
      emit(jType(0, -(pcWord * 4)));

      cnt = 0;
      while (reset !== 1'b1 && cnt < 200) begin
         @(negedge clk);
         cnt++;
      end
      if (reset !== 1'b1) begin
         $display("Timeout: reset was never released");
         $display("TEST FAILED");
         $fatal(1);
      end

      // First fetch must address the reset vector, with no write before it
      cnt = 0;
      while (memRstrb !== 1'b1 && cnt < 200) begin
         compare({28'b0, memWmask}, 32'h0, "write before first fetch");
         @(negedge clk);
         cnt++;
      end
      if (memRstrb !== 1'b1) begin
         $display("Timeout: the core never issued its first fetch");
         $display("TEST FAILED");
         $fatal(1);
      end
      compare(memAddr, resetAddr, "first fetch address");

      for (int pass = 0; pass < 2; pass++) begin
         for (int row = 0; row < expAddr.size(); row++) begin
            cnt = 0;
            @(negedge clk);
            while (memWmask == 4'b0 && cnt < 200) begin
               @(negedge clk);
               cnt++;
            end
            if (memWmask == 4'b0) begin
               $display("Timeout: no store seen for row %0d (%s) in pass %0d", row,
                        expLabel[row], pass);
               $display("TEST FAILED");
               $fatal(1);
            end
            compare(memAddr, expAddr[row], {expLabel[row], " address"});
            compare(memWdata, expData[row], {expLabel[row], " data"});
            compare({28'b0, memWmask}, {28'b0, expMask[row]}, {expLabel[row], " mask"});
         end
         // Second pass runs with random back-pressure
         randomBusy = 1'b1;
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== bench/tbClock.sv ====
// Testbench clock and reset generator
// 4 ns clock, active-low reset held for the first 8 cycles
`timescale 1ns/1ns

module tbClock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // Release reset just after the 8th rising edge
   initial begin
      reset = 1'b0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b1;
   end

endmodule

// ==== design/rvCore.sv ====
// Multi-cycle RV32I core
// Five-state FSM over one shared instruction/data port,
// one instruction in flight, stalls only on the memory busy lines
// Holds the PC, the branch and load/store address adders and write-back
`timescale 1ns/1ns

module rvCore #(
   parameter rvIsaPkg::word_t resetAddr = 32'h0000_0000,
   parameter int              addrWidth = 24
) (
   input  logic                clk,
   input  logic                reset,
   output rvIsaPkg::word_t     memAddr,
   output rvIsaPkg::word_t     memWdata,
   output rvBusPkg::byteMask_t memWmask,
   output logic                memRstrb,
   input  rvIsaPkg::word_t     memRdata,
   input  logic                memRbusy,
   input  logic                memWbusy
);
   import rvIsaPkg::*;
   import rvBusPkg::*;

   typedef logic [addrWidth-1:0] addr_t;

   typedef enum logic [2:0] {
      FETCH,
      WAITINSTR,
      EXEC1,
      EXEC2,
      WAITMEM
   } coreState_t;

   coreState_t state;
   addr_t      pc;
   addr_t      pcPlus4;
   addr_t      pcPlusImm;
   addr_t      lsAddr;
   logic       predicate;
   logic       loadWb;       // WAITMEM ends with a load write-back
   logic       capture;
   logic       wrEn;
   decoded_t   dec;
   word_t      rs1;
   word_t      rs2;
   word_t      aluResult;
   word_t      aluSum;
   logic       aluTaken;
   storeReq_t  store;
   word_t      loadData;
   word_t      wbData;
   logic       isLoad;
   logic       isStore;

   // Zero-extend an address to a bus word
   function automatic word_t padAddr(input addr_t a);
      word_t w;
      w = '0;
      w[addrWidth-1:0] = a;
      return w;
   endfunction

   assign isLoad  = (dec.opClass == LOAD);
   assign isStore = (dec.opClass == STORE);
   assign pcPlus4 = pc + addr_t'(4);

   // Instruction word is on the bus once memRbusy drops
   assign capture = (state == WAITINSTR) && !memRbusy;

   rvDecoder u0 (
      .clk       (clk),
      .capture   (capture),
      .instrWord (memRdata),
      .dec       (dec)
   );

   rvRegFile u1 (
      .clk     (clk),
      .capture (capture),
      .rs1Id   (memRdata[19:15]),
      .rs2Id   (memRdata[24:20]),
      .wrEn    (wrEn),
      .wrId    (dec.rd),
      .wrData  (wbData),
      .rs1     (rs1),
      .rs2     (rs2)
   );

   rvAlu u2 (
      .dec    (dec),
      .rs1    (rs1),
      .rs2    (rs2),
      .result (aluResult),
      .sum    (aluSum),
      .taken  (aluTaken)
   );

   rvLoadStore u3 (
      .ofs      (lsAddr[1:0]),
      .funct3   (dec.funct3),
      .rs2      (rs2),
      .rdata    (memRdata),
      .store    (store),
      .loadData (loadData)
   );

   // Instruction address while fetching, data address otherwise
   assign memAddr  = (state == FETCH || state == WAITINSTR) ? padAddr(pc) : padAddr(lsAddr);
   assign memWdata = store.data;
   assign memWmask = (state == EXEC2 && isStore) ? store.mask : '0;
   assign memRstrb = (state == FETCH) || (state == EXEC2 && isLoad);

   always_comb begin
      case (dec.opClass)
         LUI:       wbData = dec.uImm;
         AUIPC:     wbData = padAddr(pcPlusImm);
         JAL, JALR: wbData = padAddr(pcPlus4);
         LOAD:      wbData = loadData;
         default:   wbData = aluResult;
      endcase
   end

   // Loads write on the way out of WAITMEM, all else in EXEC2
   assign wrEn = (state == EXEC2 && dec.rdWrites && !isLoad) ||
                 (state == WAITMEM && loadWb && !memRbusy && !memWbusy);

   // Targets and predicate, taken while operands settle in EXEC1
   always_ff @(posedge clk) begin
      if (state == EXEC1) begin
         // JAL jumps by jImm, AUIPC adds uImm, branches add bImm
         pcPlusImm <= pc + ((dec.opClass == JAL)   ? dec.jImm[addrWidth-1:0] :
                            (dec.opClass == AUIPC) ? dec.uImm[addrWidth-1:0] :
                                                     dec.bImm[addrWidth-1:0]);
         lsAddr    <= rs1[addrWidth-1:0] +
                      (isStore ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0]);
         predicate <= aluTaken;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for the memory to go idle
         state  <= WAITMEM;
         pc     <= resetAddr[addrWidth-1:0];
         loadWb <= 1'b0;
      end else begin
         case (state)
            FETCH: state <= WAITINSTR;
            WAITINSTR: begin
               if (!memRbusy) begin
                  state <= EXEC1;
               end
            end
            EXEC1: state <= EXEC2;
            EXEC2: begin
               // JALR target has bit 0 cleared
               if (dec.opClass == JALR) begin
                  pc <= {aluSum[addrWidth-1:1], 1'b0};
               end else if (dec.opClass == JAL || (dec.opClass == BRANCH && predicate)) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               loadWb <= isLoad && dec.rdWrites;
               state  <= (isLoad || isStore) ? WAITMEM : FETCH;
            end
            default: begin
               // WAITMEM
               if (!memRbusy && !memWbusy) begin
                  loadWb <= 1'b0;
                  state  <= FETCH;
               end
            end
         endcase
      end
   end

endmodule

// ==== design/rvLoadStore.sv ====
// Load and store lane handling
// Picks the byte or halfword lane of a load and sign-extends it,
// spreads store data over the lanes and builds the write mask
`timescale 1ns/1ns

module rvLoadStore (
   input  rvBusPkg::byteOfs_t  ofs,
   input  rvIsaPkg::funct3_t   funct3,
   input  rvIsaPkg::word_t     rs2,
   input  rvIsaPkg::word_t     rdata,
   output rvBusPkg::storeReq_t store,
   output rvIsaPkg::word_t     loadData
);
   import rvBusPkg::*;

   accessSize_t size;
   logic [15:0] halfVal;
   logic [7:0]  byteVal;
   logic        signBit;

   assign size = accessSize_t'(funct3[1:0]);

   // Lane select, high half first, then byte within it
   assign halfVal = ofs[1] ? rdata[31:16] : rdata[15:0];
   assign byteVal = ofs[0] ? halfVal[15:8] : halfVal[7:0];

   // funct3[2] marks LBU and LHU
   assign signBit = !funct3[2] && ((size == BYTE) ? byteVal[7] : halfVal[15]);

   always_comb begin
      case (size)
         BYTE:    loadData = {{24{signBit}}, byteVal};
         HALF:    loadData = {{16{signBit}}, halfVal};
         default: loadData = rdata;
      endcase
   end

   // Data copied onto every lane, the mask decides which bytes land
   always_comb begin
      case (size)
         BYTE: begin
            store.data = {4{rs2[7:0]}};
            store.mask = byteMask_t'(4'b0001 << ofs);
         end
         HALF: begin
            store.data = {2{rs2[15:0]}};
            store.mask = ofs[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            store.data = rs2;
            store.mask = 4'b1111;
         end
      endcase
   end

endmodule

// ==== design/rvAlu.sv ====
// Integer ALU and branch comparator
// One adder, one 33-bit subtract for SUB and all compares,
// a single right shifter reused for left shifts by bit reversal
`timescale 1ns/1ns

module rvAlu (
   input  rvIsaPkg::decoded_t dec,
   input  rvIsaPkg::word_t    rs1,
   input  rvIsaPkg::word_t    rs2,
   output rvIsaPkg::word_t    result,
   output rvIsaPkg::word_t    sum,
   output logic               taken
);
   import rvIsaPkg::*;

   word_t             in2;
   word_t             shIn;
   word_t             shOut;
   logic [32:0]       diff;
   logic signed [32:0] shSigned;
   logic [32:0]       shWide;
   logic              lt;
   logic              ltu;
   logic              eq;

   // Mirror a word end for end
   function automatic word_t flip(input word_t x);
      word_t y;
      for (int i = 0; i < 32; i++) begin
         y[i] = x[31 - i];
      end
      return y;
   endfunction

   // Register ops and branches compare rs2, everything else uses the I-immediate
   assign in2 = (dec.opClass == ALUREG || dec.opClass == BRANCH) ? rs2 : dec.iImm;

   // Also the JALR target
   assign sum = rs1 + in2;

   // rs1 - in2 with a borrow bit on top
   assign diff = {1'b1, ~in2} + {1'b0, rs1} + 33'd1;
   assign ltu  = diff[32];
   // Signs differ, so rs1 is lower exactly when it is negative
   assign lt   = (rs1[31] ^ in2[31]) ? rs1[31] : diff[32];
   assign eq   = (diff[31:0] == '0);

   // Extra top bit carries the sign for SRA, zero for SRL and SLL
   assign shIn     = (dec.funct3 == f3Sll) ? flip(rs1) : rs1;
   assign shSigned = {dec.subOrArith & rs1[31], shIn};
   assign shWide   = shSigned >>> in2[4:0];
   assign shOut    = shWide[31:0];

   always_comb begin
      case (dec.funct3)
         // ADDI has bit 30 inside its immediate, so bit 5 must qualify SUB
         f3AddSub: result = (dec.subOrArith && dec.isRegOp) ? diff[31:0] : sum;
         f3Sll:    result = flip(shOut);
         f3Slt:    result = {31'b0, lt};
         f3Sltu:   result = {31'b0, ltu};
         f3Xor:    result = rs1 ^ in2;
         f3Shr:    result = shOut;
         f3Or:     result = rs1 | in2;
         f3And:    result = rs1 & in2;
      endcase
   end

   // Branch predicate, only looked at for branches
   always_comb begin
      case (dec.funct3)
         f3Beq:   taken = eq;
         f3Bne:   taken = !eq;
         f3Blt:   taken = lt;
         f3Bge:   taken = !lt;
         f3Bltu:  taken = ltu;
         f3Bgeu:  taken = !ltu;
         default: taken = 1'b0;
      endcase
   end

endmodule

// ==== design/rvRegFile.sv ====
// Integer register file
// 32 words, one write port, two operands registered on capture
// x0 always reads as zero
`timescale 1ns/1ns

module rvRegFile (
   input  logic            clk,
   input  logic            capture,
   input  rvIsaPkg::regId_t rs1Id,
   input  rvIsaPkg::regId_t rs2Id,
   input  logic            wrEn,
   input  rvIsaPkg::regId_t wrId,
   input  rvIsaPkg::word_t wrData,
   output rvIsaPkg::word_t rs1,
   output rvIsaPkg::word_t rs2
);
   import rvIsaPkg::*;

   word_t regs [32];

   // Write port, x0 may hold junk since reads mask it
   always_ff @(posedge clk) begin
      if (wrEn) begin
         regs[wrId] <= wrData;
      end
   end

   // Operand read, indices come straight from the fetched word
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

// ==== design/rvDecoder.sv ====
// Instruction decoder
// Classifies the fetched word and builds all five immediates,
// registered on the capture pulse so results show up one cycle later
`timescale 1ns/1ns

module rvDecoder (
   input  logic               clk,
   input  logic               capture,
   input  rvIsaPkg::word_t    instrWord,
   output rvIsaPkg::decoded_t dec
);
   import rvIsaPkg::*;

   instrClass_t cls;

   // Opcode bits 1:0 are always 11 in RV32I, only 6:2 matter
   always_comb begin
      case (instrWord[6:2])
         5'b00000: cls = LOAD;
         5'b01000: cls = STORE;
         5'b00100: cls = ALUIMM;
         5'b01100: cls = ALUREG;
         5'b11000: cls = BRANCH;
         5'b11001: cls = JALR;
         5'b11011: cls = JAL;
         5'b01101: cls = LUI;
         5'b00101: cls = AUIPC;
         default:  cls = ILLEGAL;
      endcase
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         dec.opClass    <= cls;
         dec.funct3     <= instrWord[14:12];
         dec.rd         <= instrWord[11:7];
         // Done once here so later stages never compare rd with zero
         dec.rdWrites   <= (|instrWord[11:7]) && !(cls inside {BRANCH, STORE, ILLEGAL});
         dec.subOrArith <= instrWord[30];
         dec.isRegOp    <= instrWord[5];

         // Upper immediate, low 12 bits cleared
         dec.uImm <= {instrWord[31:12], 12'b0};
         dec.iImm <= {{21{instrWord[31]}}, instrWord[30:20]};
         dec.sImm <= {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
         // Branch and jump offsets are in halfwords, bit 0 always zero
         dec.bImm <= {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                      instrWord[11:8], 1'b0};
         dec.jImm <= {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                      instrWord[30:21], 1'b0};
      end
   end

endmodule

// ==== design/rvBusPkg.sv ====
// Memory-bus types of the core
// Write mask, low address bits, store request and access size
package rvBusPkg;

   // One enable bit per byte lane
   typedef logic [3:0] byteMask_t;

   // Byte offset within a word
   typedef logic [1:0] byteOfs_t;

   // Store data already placed on its lanes, with the lane mask
   typedef struct packed {
      rvIsaPkg::word_t data;
      byteMask_t       mask;
   } storeReq_t;

   // Access size, straight from funct3[1:0]
   typedef enum logic [1:0] {
      BYTE = 2'b00,
      HALF = 2'b01,
      WORD = 2'b10
   } accessSize_t;

endpackage

// ==== design/rvIsaPkg.sv ====
// RV32I instruction-set types
// Data word, register index, funct3 field and its codes,
// the instruction class and the decoded-instruction record
package rvIsaPkg;

   // Data and instruction word
   typedef logic [31:0] word_t;

   // Register index, x0..x31
   typedef logic [4:0] regId_t;

   // funct3 field of an instruction
   typedef logic [2:0] funct3_t;

   // Opcode classes of the base integer set
   // ILLEGAL covers anything else and never writes back
   typedef enum logic [3:0] {
      LOAD,
      STORE,
      ALUIMM,
      ALUREG,
      BRANCH,
      JAL,
      JALR,
      LUI,
      AUIPC,
      ILLEGAL
   } instrClass_t;

   // Decoded instruction, registered once per fetch
   typedef struct packed {
      instrClass_t opClass;
      funct3_t     funct3;
      regId_t      rd;
      logic        rdWrites;    // rd is nonzero and the class writes back
      logic        subOrArith;  // Bit 30, SUB or SRA/SRAI
      logic        isRegOp;     // Bit 5, register form of ALU ops
      word_t       uImm;
      word_t       iImm;
      word_t       sImm;
      word_t       bImm;
      word_t       jImm;
   } decoded_t;

   // ALU operation codes
   localparam funct3_t f3AddSub = 3'b000;
   localparam funct3_t f3Sll    = 3'b001;
   localparam funct3_t f3Slt    = 3'b010;
   localparam funct3_t f3Sltu   = 3'b011;
   localparam funct3_t f3Xor    = 3'b100;
   localparam funct3_t f3Shr    = 3'b101;  // SRL or SRA by bit 30
   localparam funct3_t f3Or     = 3'b110;
   localparam funct3_t f3And    = 3'b111;

   // Branch condition codes
   localparam funct3_t f3Beq  = 3'b000;
   localparam funct3_t f3Bne  = 3'b001;
   localparam funct3_t f3Blt  = 3'b100;
   localparam funct3_t f3Bge  = 3'b101;
   localparam funct3_t f3Bltu = 3'b110;
   localparam funct3_t f3Bgeu = 3'b111;

endpackage
